// ==== source/uart_host_pkg.sv ====
/* UART host shared definitions */

`default_nettype none

package uart_host_pkg;

    // Clock cycles per serial bit, kept short for simulation
    localparam int baud_div = 16;

    // Data bits per 8-N-1 frame
    localparam int data_bits = 8;

    // Counter widths derived from the frame timing
    localparam int baud_cnt_w = $clog2(baud_div);
    localparam int bit_cnt_w  = $clog2(data_bits);

    // Two-byte sequence that fires the forced reset
    localparam logic [7:0] trig_first  = 8'hA5;
    localparam logic [7:0] trig_second = 8'h3C;

    typedef logic [data_bits-1:0] uart_byte_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    // Trigger monitor FSM
    typedef enum logic {
        TRIG_WAIT_FIRST,
        TRIG_ARMED
    } trig_state_t;

endpackage

`default_nettype wire

// ==== source/uart_tx.sv ====
/* UART transmitter, 8-N-1 */

`default_nettype none

module uart_tx
    import uart_host_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        force_reset,
    input  uart_byte_t tx_data,
    input  wire        tx_start,
    output logic       tx_out,
    output logic       tx_busy
);

    tx_state_t             state;
    logic [baud_cnt_w-1:0] baud_cnt;
    logic [bit_cnt_w-1:0]  bit_cnt;
    uart_byte_t            shift;
    logic                  bit_end;
    logic                  accept;

    assign bit_end = (baud_cnt == baud_cnt_w'(baud_div - 1));   // Last cycle of a bit
    assign accept  = (state == TX_IDLE) && tx_start;           // Only taken while idle

    // Frame sequencing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_out   <= 1'b1;
            tx_busy  <= 1'b0;
        end else if (force_reset) begin
            // Abort whatever frame is on the line
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_out   <= 1'b1;
            tx_busy  <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    tx_out <= 1'b1;
                    if (tx_start) begin
                        state    <= TX_START;
                        tx_out   <= 1'b0;       // Start bit
                        tx_busy  <= 1'b1;
                        baud_cnt <= '0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state    <= TX_DATA;
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        tx_out   <= shift[0];   // LSB first
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        if (bit_cnt == bit_cnt_w'(data_bits - 1)) begin
                            state  <= TX_STOP;
                            tx_out <= 1'b1;     // Stop bit
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx_out  <= shift[1]; // Shift happens on this same edge
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state    <= TX_IDLE;
                        baud_cnt <= '0;
                        tx_busy  <= 1'b0;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Data shift register
    always_ff @(posedge clk) begin
        if (accept) begin
            shift <= tx_data;
        end else if (state == TX_DATA && bit_end) begin
            shift <= {1'b0, shift[data_bits-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
/* UART receiver with mid-bit sampling */

`default_nettype none

module uart_rx
    import uart_host_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        force_reset,
    input  wire        rx_in,
    output uart_byte_t rx_data,
    output logic       rx_valid,
    output logic       rx_frame_err
);

    rx_state_t             state;
    logic [baud_cnt_w-1:0] baud_cnt;
    logic [bit_cnt_w-1:0]  bit_cnt;
    uart_byte_t            shift;
    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;
    logic                  fall;
    logic                  half_bit;
    logic                  full_bit;

    // Two-flop synchronizer plus one stage for edge detect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_in;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall     = rx_prev && !rx_sync;
    assign half_bit = (baud_cnt == baud_cnt_w'(baud_div / 2 - 1));
    assign full_bit = (baud_cnt == baud_cnt_w'(baud_div - 1));    // Centre of next bit

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= RX_IDLE;
            baud_cnt     <= '0;
            bit_cnt      <= '0;
            rx_data      <= '0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else if (force_reset) begin
            state        <= RX_IDLE;
            baud_cnt     <= '0;
            bit_cnt      <= '0;
            rx_data      <= '0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_valid     <= 1'b0;   // Pulses last one cycle
            rx_frame_err <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (fall) begin
                        state    <= RX_START;
                        baud_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (half_bit) begin
                        baud_cnt <= '0;
                        if (rx_sync) begin
                            state <= RX_IDLE;   // Glitch, not a start bit
                        end else begin
                            state   <= RX_DATA;
                            bit_cnt <= '0;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (full_bit) begin
                        baud_cnt <= '0;
                        if (bit_cnt == bit_cnt_w'(data_bits - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (full_bit) begin
                        state    <= RX_IDLE;
                        baud_cnt <= '0;
                        if (rx_sync) begin
                            rx_data  <= shift;
                            rx_valid <= 1'b1;
                        end else begin
                            rx_frame_err <= 1'b1;   // Stop bit seen low
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && full_bit) begin
            shift <= {rx_sync, shift[data_bits-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== source/trigger_monitor.sv ====
/* Two-byte trigger monitor */

`default_nettype none

module trigger_monitor
    import uart_host_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  uart_byte_t rx_data,
    input  wire        rx_valid,
    output logic       force_reset
);

    trig_state_t state;
    trig_state_t state_next;
    logic        fire;

    // Sequence rule, evaluated only on a received byte
    always_comb begin
        state_next = state;
        fire       = 1'b0;
        if (rx_valid) begin
            case (state)
                TRIG_WAIT_FIRST: begin
                    if (rx_data == trig_first) begin
                        state_next = TRIG_ARMED;
                    end
                end
                TRIG_ARMED: begin
                    if (rx_data == trig_second) begin
                        state_next = TRIG_WAIT_FIRST;
                        fire       = 1'b1;
                    end else if (rx_data != trig_first) begin
                        state_next = TRIG_WAIT_FIRST;   // Repeated first byte stays armed
                    end
                end
                default: state_next = TRIG_WAIT_FIRST;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= TRIG_WAIT_FIRST;
            force_reset <= 1'b0;
        end else begin
            state       <= state_next;
            force_reset <= fire;        // Single cycle, one after rx_valid
        end
    end

endmodule

`default_nettype wire

// ==== source/uart_host.sv ====
/* UART host top level */

`default_nettype none

module uart_host
    import uart_host_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  uart_byte_t tx_data,
    input  wire        tx_start,
    input  wire        rx_in,
    output logic       tx_out,
    output logic       tx_busy,
    output uart_byte_t rx_data,
    output logic       rx_valid,
    output logic       rx_frame_err
);

    // Clears both engines when the trigger sequence is seen
    logic force_reset;

    uart_tx tx_inst (
        .clk         (clk),
        .rst         (rst),
        .force_reset (force_reset),
        .tx_data     (tx_data),
        .tx_start    (tx_start),
        .tx_out      (tx_out),
        .tx_busy     (tx_busy)
    );

    uart_rx rx_inst (
        .clk          (clk),
        .rst          (rst),
        .force_reset  (force_reset),
        .rx_in        (rx_in),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err)
    );

    // Watches the same byte stream the host sees
    trigger_monitor trig_inst (
        .clk         (clk),
        .rst         (rst),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .force_reset (force_reset)
    );

endmodule

`default_nettype wire

// ==== bench/uart_host_tb.sv ====
/* UART host testbench */

`default_nettype none

module uart_host_tb
    import uart_host_pkg::*;
();

    localparam int clk_half     = 20;
    localparam int reset_cycles = 10;
    localparam int frame_cycles = 10 * baud_div;
    // Frame budget per test is tx 10, rx 9, framing 3, abort 4 and trigger rule 10
    localparam int test_frames  = 10 + 9 + 3 + 4 + 10;
    localparam int watchdog_time = 2 * (reset_cycles + test_frames * frame_cycles) * 2 * clk_half;

    logic       clk = 1'b0;
    logic       rst;
    uart_byte_t tx_data;
    logic       tx_start;
    logic       rx_in;
    logic       tx_out;
    logic       tx_busy;
    uart_byte_t rx_data;
    logic       rx_valid;
    logic       rx_frame_err;

    int          seed = 32'h7829_bb58;
    string       test_name = "reset";
    int          errors;
    int          errors_at_start;
    int          pass_count;
    int          fail_count;
    int          valid_count;
    int          err_count;
    trig_state_t trig_model;
    logic        model_fire;
    uart_byte_t  exp_bytes[$];     // Bytes driven on rx_in in arrival order

    uart_host uart_host_inst (
        .clk          (clk),
        .rst          (rst),
        .tx_data      (tx_data),
        .tx_start     (tx_start),
        .rx_in        (rx_in),
        .tx_out       (tx_out),
        .tx_busy      (tx_busy),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err)
    );

    always #(clk_half) clk = ~clk;

    // Armed by the first byte and fires on the second right after it
    function automatic trig_state_t next_trig(input trig_state_t st, input uart_byte_t b,
                                              output logic fire);
        fire = 1'b0;
        if (st == TRIG_ARMED && b == trig_second) begin
            fire = 1'b1;
            return TRIG_WAIT_FIRST;
        end
        if (b == trig_first) begin
            return TRIG_ARMED;
        end
        return TRIG_WAIT_FIRST;
    endfunction

    task automatic check_byte(input string what, input uart_byte_t expected,
                              input uart_byte_t actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %b actual %b", what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL %s expected %0d actual %0d", what, expected, actual);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        errors++;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            pass_count++;
            $display("test %s: ok", test_name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // Inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic pick_byte(output uart_byte_t b);
        int r;
        r = $random(seed);
        b = r[data_bits-1:0];
        while (b == trig_first) begin   // Would arm the monitor by accident
            r = $random(seed);
            b = r[data_bits-1:0];
        end
    endtask

    task automatic start_tx(input uart_byte_t b);
        tx_data  = b;
        tx_start = 1'b1;
        next_cycle();
        tx_start = 1'b0;
    endtask

    // One 8-N-1 frame on rx_in plus one idle bit
    task automatic drive_frame(input uart_byte_t b, input logic stop_val);
        rx_in = 1'b0;
        repeat (baud_div) next_cycle();
        for (int i = 0; i < data_bits; i++) begin
            rx_in = b[i];
            repeat (baud_div) next_cycle();
        end
        rx_in = stop_val;
        repeat (baud_div) next_cycle();
        rx_in = 1'b1;
        repeat (baud_div) next_cycle();
    endtask

    task automatic wait_rx_event(input logic want_err, output logic seen);
        seen = 1'b0;
        for (int n = 0; n < 2 * frame_cycles && !seen; n++) begin
            @(negedge clk);
            if (want_err ? rx_frame_err : rx_valid) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic receive_frame(input uart_byte_t b, input logic good_stop);
        logic seen;
        if (good_stop) begin
            exp_bytes.push_back(b);
        end
        fork
            drive_frame(b, good_stop);
            wait_rx_event(!good_stop, seen);
        join
        if (!seen && good_stop) begin
            report_failure("no rx_valid within frame time");
        end else if (!seen) begin
            report_failure("no rx_frame_err within frame time");
        end
    endtask

    // Bit centres on tx_out timed from the start-bit edge
    task automatic sample_frame(output uart_byte_t data, output logic start_bit,
                                output logic stop_bit);
        @(negedge tx_out);
        repeat (baud_div / 2) @(negedge clk);
        start_bit = tx_out;
        for (int i = 0; i < data_bits; i++) begin
            repeat (baud_div) @(negedge clk);
            data[i] = tx_out;
        end
        repeat (baud_div) @(negedge clk);
        stop_bit = tx_out;
    endtask

    task automatic count_busy(output int cycles);
        cycles = 0;
        @(posedge tx_busy);
        while (tx_busy) begin
            @(negedge clk);
            if (tx_busy) begin
                cycles++;
            end
        end
    endtask

    task automatic wait_tx_idle();
        int n;
        n = 0;
        while (tx_busy && n < 2 * frame_cycles) begin
            @(negedge clk);
            n++;
        end
        if (tx_busy) begin
            report_failure("tx_busy still high after frame time");
        end
    endtask

    task automatic transmit_and_check(input uart_byte_t b, input logic poke_mid);
        uart_byte_t got;
        logic       start_bit;
        logic       stop_bit;
        int         busy_cycles;
        logic       busy_seen;
        logic       line_high;
        next_cycle();
        fork
            sample_frame(got, start_bit, stop_bit);
            count_busy(busy_cycles);
            begin
                start_tx(b);
                if (poke_mid) begin
                    repeat (3 * baud_div) next_cycle();   // Inside the data bits
                    start_tx(~b);
                end
            end
        join
        check_bit({test_name, " start bit"}, 1'b0, start_bit);
        check_byte({test_name, " data bits"}, b, got);
        check_bit({test_name, " stop bit"}, 1'b1, stop_bit);
        check_count({test_name, " busy cycles"}, frame_cycles, busy_cycles);
        busy_seen = 1'b0;
        line_high = 1'b1;
        repeat (2 * baud_div) begin
            @(negedge clk);
            busy_seen = busy_seen | tx_busy;
            line_high = line_high & tx_out;
        end
        check_bit({test_name, " busy after frame"}, 1'b0, busy_seen);
        check_bit({test_name, " line idle after frame"}, 1'b1, line_high);
    endtask

    // Last byte of seq arrives while a transmission is running
    task automatic run_trigger_case(input uart_byte_t seq[3], input int len);
        logic        seen;
        logic        idle_seen;
        uart_byte_t  payload;
        for (int i = 0; i < len - 1; i++) begin
            receive_frame(seq[i], 1'b1);
        end
        pick_byte(payload);
        idle_seen = 1'b0;
        exp_bytes.push_back(seq[len-1]);
        fork
            drive_frame(seq[len-1], 1'b1);
            begin
                repeat (baud_div) next_cycle();   // One bit into the frame
                start_tx(payload);
            end
            begin
                wait_rx_event(1'b0, seen);
                repeat (3) begin
                    @(negedge clk);
                    idle_seen = idle_seen | (!tx_busy && tx_out);
                end
            end
        join
        if (!seen) begin
            report_failure("no rx_valid within frame time");
        end
        // Model has stepped on the last byte by now
        check_bit({test_name, " transmit aborted"}, model_fire, idle_seen);
        wait_tx_idle();
    endtask

    // Every received pulse is checked against the driven bytes
    always @(negedge clk) begin
        if (!rst && rx_valid) begin
            valid_count++;
            if (exp_bytes.size() == 0) begin
                report_failure("rx_valid with no byte driven");
                trig_model = next_trig(trig_model, rx_data, model_fire);
            end else begin
                check_byte({test_name, " rx_data"}, exp_bytes[0], rx_data);
                trig_model = next_trig(trig_model, exp_bytes.pop_front(), model_fire);
            end
        end
        if (!rst && rx_frame_err) begin
            err_count++;
        end
    end

    initial begin
        #(watchdog_time);
        $display("Watchdog expired during test %s, run exceeded its time budget", test_name);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        uart_byte_t b;
        uart_byte_t seq[3];
        int         before_valid;
        int         before_err;
        rst         = 1'b1;
        tx_data     = '0;
        tx_start    = 1'b0;
        rx_in       = 1'b1;
        errors      = 0;
        pass_count  = 0;
        fail_count  = 0;
        valid_count = 0;
        err_count   = 0;
        trig_model  = TRIG_WAIT_FIRST;
        model_fire  = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (4) next_cycle();

        for (int i = 0; i < 8; i++) begin
            pick_byte(b);
            begin_test($sformatf("tx_frame_%0d", i));
            transmit_and_check(b, (i % 2) == 1);
            end_test();
        end

        for (int i = 0; i < 8; i++) begin
            pick_byte(b);
            begin_test($sformatf("rx_byte_%0d", i));
            before_valid = valid_count;
            receive_frame(b, 1'b1);
            check_count({test_name, " rx_valid pulses"}, before_valid + 1, valid_count);
            end_test();
        end

        begin_test("frame_error");
        pick_byte(b);
        before_valid = valid_count;
        before_err   = err_count;
        receive_frame(b, 1'b0);
        check_count({test_name, " rx_frame_err pulses"}, before_err + 1, err_count);
        check_count({test_name, " rx_valid pulses"}, before_valid, valid_count);
        pick_byte(b);
        receive_frame(b, 1'b1);
        check_count({test_name, " rx_valid after error"}, before_valid + 1, valid_count);
        end_test();

        begin_test("trigger_abort");
        seq = '{trig_first, trig_second, 8'h00};
        run_trigger_case(seq, 2);
        pick_byte(b);
        transmit_and_check(b, 1'b0);
        end_test();

        begin_test("trigger_broken_sequence");
        seq = '{trig_first, 8'h00, trig_second};
        run_trigger_case(seq, 3);
        end_test();

        begin_test("trigger_wrong_order");
        seq = '{trig_second, trig_first, 8'h00};
        run_trigger_case(seq, 2);
        end_test();

        begin_test("trigger_repeated_first");
        seq = '{trig_first, trig_first, trig_second};
        run_trigger_case(seq, 3);
        end_test();

        if (exp_bytes.size() != 0) begin
            report_failure("driven bytes were never received");
        end
        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
        if (errors == 0 && fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/uart_host_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/trigger_monitor.sv
source/uart_host.sv
bench/uart_host_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART host testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

verilator --binary --timing --top-module uart_host_tb -f files.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vuart_host_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation passed" sim.log; then
    echo "Result: pass"
    exit 0
fi

echo "Result: fail"
exit 1
